// ==== cpu_pkg.sv ====
package cpu_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [4:0]  reg_idx_t;

	// RV32I major opcodes.
	localparam logic [6:0] OP_R      = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;
	localparam xlen_t      INST_ECALL = 32'h0000_0073;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_PASSB
	} alu_op_t;

	typedef enum logic [1:0] {
		FWD_REG,
		FWD_MEM,
		FWD_WB
	} fwd_sel_t;

	// All zero is a bubble.
	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    use_imm;
		logic    is_beq;
		logic    is_bne;
		logic    is_jal;
		logic    is_halt;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		xlen_t pc;
		xlen_t inst;
	} if_id_t;

	typedef struct packed {
		xlen_t    pc;
		xlen_t    rs1_val;
		xlen_t    rs2_val;
		xlen_t    imm;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		ctrl_t    ctrl;
	} id_ex_t;

	typedef struct packed {
		xlen_t    alu_out;
		xlen_t    store_data;
		reg_idx_t rd;
		ctrl_t    ctrl;
	} ex_mem_t;

	typedef struct packed {
		xlen_t    alu_out;
		xlen_t    load_data;
		reg_idx_t rd;
		ctrl_t    ctrl;
	} mem_wb_t;

	// APB map. Word index in a window is paddr[9:2].
	localparam logic [11:0] CTRL_ADDR   = 12'h000;
	localparam logic [11:0] STATUS_ADDR = 12'h004;
	localparam logic [11:0] CYCLES_ADDR = 12'h008;
	localparam logic [11:0] IMEM_BASE   = 12'h400;
	localparam logic [11:0] DMEM_BASE   = 12'h800;

	// Value written back to the register file.
	function automatic xlen_t wb_value(mem_wb_t w);
		return w.ctrl.memread ? w.load_data : w.alu_out;
	endfunction

endpackage

// ==== pipe_reg.sv ====
`timescale 1ns/1ns

module pipe_reg #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     input_clk,
	input  logic     rst,
	input  logic     stall,
	input  logic     flush,
	input  payload_t d,
	output payload_t q
);

	// Flush beats stall and leaves a bubble.
	always_ff @(posedge input_clk) begin
		if (rst || flush)
			q <= '0;
		else if (!stall)
			q <= d;
	end

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ns

module fetch_stage import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input  logic       input_clk,
	input  logic       rst,
	input  logic       hold,
	input  logic       redirect,
	input  xlen_t      target,
	input  logic       imem_we,
	input  logic [7:0] mem_addr,
	input  xlen_t      mem_wdata,
	output if_id_t     out_if,
	output xlen_t      pc
);

	localparam int IAW = $clog2(IMEM_WORDS);

	xlen_t imem [IMEM_WORDS];
	xlen_t next_pc;

	// A redirect from EX is older than any hold.
	always_comb begin
		if (redirect)
			next_pc = target;
		else if (hold)
			next_pc = pc;
		else
			next_pc = pc + 32'd4;
	end

	always_ff @(posedge input_clk) begin
		if (rst)
			pc <= '0;
		else
			pc <= next_pc;
	end

	// Loaded over APB.
	always_ff @(posedge input_clk) begin
		if (imem_we)
			imem[mem_addr[IAW-1:0]] <= mem_wdata;
	end

	assign out_if.pc   = pc;
	assign out_if.inst = imem[pc[IAW+1:2]];

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage import cpu_pkg::*; (
	input  logic     input_clk,
	input  logic     rst,
	input  if_id_t   in_if,
	input  mem_wb_t  wb,
	input  reg_idx_t ex_rd,
	input  logic     ex_memread,
	output id_ex_t   out_id,
	output logic     hazard,
	output logic     halt_wb
);

	xlen_t    regs [32];
	xlen_t    inst;
	xlen_t    imm;
	reg_idx_t rs1;
	reg_idx_t rs2;
	reg_idx_t rd;
	logic     use_rs1;
	logic     use_rs2;
	ctrl_t    ctrl;

	// Write-through from writeback.
	function automatic xlen_t read_reg(reg_idx_t idx, xlen_t stored, mem_wb_t w);
		if (idx == '0)
			return '0;
		if (w.ctrl.regwrite && w.rd == idx)
			return wb_value(w);
		return stored;
	endfunction

	assign inst = in_if.inst;
	assign rs1  = inst[19:15];
	assign rs2  = inst[24:20];
	assign rd   = inst[11:7];

	always_ff @(posedge input_clk) begin
		if (!rst && wb.ctrl.regwrite && wb.rd != '0)
			regs[wb.rd] <= wb_value(wb);
	end

	always_comb begin
		ctrl    = '0;
		imm     = {{20{inst[31]}}, inst[31:20]};
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		case (inst[6:0])
			OP_R: begin
				use_rs1       = 1'b1;
				use_rs2       = 1'b1;
				ctrl.regwrite = 1'b1;
				case (inst[14:12])
					3'b000: ctrl.alu_op = inst[30] ? ALU_SUB : ALU_ADD;
					3'b010: ctrl.alu_op = ALU_SLT;
					3'b100: ctrl.alu_op = ALU_XOR;
					3'b110: ctrl.alu_op = ALU_OR;
					3'b111: ctrl.alu_op = ALU_AND;
					default: ctrl.regwrite = 1'b0;
				endcase
			end
			OP_IMM: begin
				use_rs1       = 1'b1;
				ctrl.use_imm  = 1'b1;
				ctrl.regwrite = (inst[14:12] == 3'b000);
			end
			OP_LOAD: begin
				use_rs1       = 1'b1;
				ctrl.use_imm  = 1'b1;
				ctrl.regwrite = (inst[14:12] == 3'b010);
				ctrl.memread  = (inst[14:12] == 3'b010);
			end
			OP_STORE: begin
				use_rs1       = 1'b1;
				use_rs2       = 1'b1;
				ctrl.use_imm  = 1'b1;
				ctrl.memwrite = (inst[14:12] == 3'b010);
				imm           = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			end
			OP_BRANCH: begin
				use_rs1     = 1'b1;
				use_rs2     = 1'b1;
				ctrl.is_beq = (inst[14:12] == 3'b000);
				ctrl.is_bne = (inst[14:12] == 3'b001);
				imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			end
			OP_JAL: begin
				ctrl.regwrite = 1'b1;
				ctrl.is_jal   = 1'b1;
				ctrl.alu_op   = ALU_PASSB;
				imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			OP_SYSTEM: ctrl.is_halt = (inst == INST_ECALL);
			default: ctrl = '0;
		endcase
	end

	always_comb begin
		out_id.pc      = in_if.pc;
		out_id.rs1_val = read_reg(rs1, regs[rs1], wb);
		out_id.rs2_val = read_reg(rs2, regs[rs2], wb);
		out_id.imm     = imm;
		out_id.rs1     = rs1;
		out_id.rs2     = rs2;
		out_id.rd      = rd;
		out_id.ctrl    = ctrl;
	end

	// Load in EX feeding this instruction.
	assign hazard = ex_memread && ex_rd != '0 &&
		((use_rs1 && ex_rd == rs1) || (use_rs2 && ex_rd == rs2));

	assign halt_wb = wb.ctrl.is_halt;

endmodule

// ==== forward_unit.sv ====
`timescale 1ns/1ns

module forward_unit import cpu_pkg::*; (
	input  id_ex_t   ex,
	input  ex_mem_t  mem,
	input  mem_wb_t  wb,
	output fwd_sel_t sel_a,
	output fwd_sel_t sel_b,
	output fwd_sel_t sel_store
);

	// The younger producer in MEM wins over WB.
	function automatic fwd_sel_t pick(
		reg_idx_t src,
		reg_idx_t mem_rd,
		logic     mem_we,
		reg_idx_t wb_rd,
		logic     wb_we
	);
		if (src == '0)
			return FWD_REG;
		if (mem_we && mem_rd == src)
			return FWD_MEM;
		if (wb_we && wb_rd == src)
			return FWD_WB;
		return FWD_REG;
	endfunction

	assign sel_a = pick(ex.rs1, mem.rd, mem.ctrl.regwrite, wb.rd, wb.ctrl.regwrite);
	assign sel_b = pick(ex.rs2, mem.rd, mem.ctrl.regwrite, wb.rd, wb.ctrl.regwrite);

	// store data only matters for sw
	assign sel_store = ex.ctrl.memwrite ? sel_b : FWD_REG;

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage import cpu_pkg::*; (
	input  id_ex_t   in_ex,
	input  xlen_t    mem_fwd,
	input  xlen_t    wb_fwd,
	input  fwd_sel_t sel_a,
	input  fwd_sel_t sel_b,
	input  fwd_sel_t sel_store,
	output ex_mem_t  out_ex,
	output logic     redirect,
	output xlen_t    target
);

	xlen_t op_a;
	xlen_t rs2_fwd;
	xlen_t op_b;
	xlen_t result;
	logic  equal;
	logic  taken;

	function automatic xlen_t fwd_mux(
		fwd_sel_t sel,
		xlen_t    reg_val,
		xlen_t    mem_val,
		xlen_t    wb_val
	);
		case (sel)
			FWD_MEM: return mem_val;
			FWD_WB:  return wb_val;
			default: return reg_val;
		endcase
	endfunction

	assign op_a    = fwd_mux(sel_a, in_ex.rs1_val, mem_fwd, wb_fwd);
	assign rs2_fwd = fwd_mux(sel_b, in_ex.rs2_val, mem_fwd, wb_fwd);

	// jal links through pass-B.
	always_comb begin
		if (in_ex.ctrl.is_jal)
			op_b = in_ex.pc + 32'd4;
		else if (in_ex.ctrl.use_imm)
			op_b = in_ex.imm;
		else
			op_b = rs2_fwd;
	end

	always_comb begin
		case (in_ex.ctrl.alu_op)
			ALU_SUB:   result = op_a - op_b;
			ALU_AND:   result = op_a & op_b;
			ALU_OR:    result = op_a | op_b;
			ALU_XOR:   result = op_a ^ op_b;
			ALU_SLT:   result = {31'd0, $signed(op_a) < $signed(op_b)};
			ALU_PASSB: result = op_b;
			default:   result = op_a + op_b;
		endcase
	end

	// Branches compare the forwarded registers.
	assign equal    = (op_a == rs2_fwd);
	assign taken    = (in_ex.ctrl.is_beq && equal) || (in_ex.ctrl.is_bne && !equal);
	assign redirect = in_ex.ctrl.is_jal || taken;
	assign target   = in_ex.pc + in_ex.imm;

	always_comb begin
		out_ex.alu_out    = result;
		out_ex.store_data = fwd_mux(sel_store, in_ex.rs2_val, mem_fwd, wb_fwd);
		out_ex.rd         = in_ex.rd;
		out_ex.ctrl       = in_ex.ctrl;
	end

endmodule

// ==== memory_stage.sv ====
`timescale 1ns/1ns

module memory_stage import cpu_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic       input_clk,
	input  logic       rst,
	input  ex_mem_t    in_mem,
	output mem_wb_t    out_wb,
	input  logic       dmem_we,
	input  logic [7:0] dmem_addr,
	input  xlen_t      mem_wdata,
	output xlen_t      dmem_rdata
);

	localparam int DAW = $clog2(DMEM_WORDS);

	xlen_t          dmem [DMEM_WORDS];
	logic [DAW-1:0] core_idx;

	assign core_idx = in_mem.alu_out[DAW+1:2];

	// One write port shared by APB and sw.
	always_ff @(posedge input_clk) begin
		if (dmem_we)
			dmem[dmem_addr[DAW-1:0]] <= mem_wdata;
		else if (in_mem.ctrl.memwrite)
			dmem[core_idx] <= in_mem.store_data;
	end

	// APB read data lands one cycle late.
	always_ff @(posedge input_clk) begin
		if (rst)
			dmem_rdata <= '0;
		else
			dmem_rdata <= dmem[dmem_addr[DAW-1:0]];
	end

	always_comb begin
		out_wb.alu_out   = in_mem.alu_out;
		out_wb.load_data = dmem[core_idx];
		out_wb.rd        = in_mem.rd;
		out_wb.ctrl      = in_mem.ctrl;
	end

endmodule

// ==== cpu_ctrl_apb.sv ====
`timescale 1ns/1ns

module cpu_ctrl_apb import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic        input_clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  xlen_t       pwdata,
	output xlen_t       prdata,
	output logic        pready,
	output logic        pslverr,
	input  logic        halt_wb,
	input  xlen_t       dmem_rdata,
	output logic        run,
	output logic        halted,
	output logic        imem_we,
	output logic        dmem_we,
	output logic [7:0]  mem_addr,
	output xlen_t       mem_wdata
);

	logic  sel_ctrl;
	logic  sel_status;
	logic  sel_cycles;
	logic  sel_imem;
	logic  sel_dmem;
	logic  addr_err;
	logic  access;
	logic  ctrl_wr;
	xlen_t cycles;
	xlen_t rd_mux;

	assign sel_ctrl   = (paddr == CTRL_ADDR);
	assign sel_status = (paddr == STATUS_ADDR);
	assign sel_cycles = (paddr == CYCLES_ADDR);
	assign sel_imem   = (paddr[11:10] == IMEM_BASE[11:10]) && (paddr[9:2] < IMEM_WORDS);
	assign sel_dmem   = (paddr[11:10] == DMEM_BASE[11:10]) && (paddr[9:2] < DMEM_WORDS);

	assign addr_err = !(sel_ctrl || sel_status || sel_cycles || sel_imem || sel_dmem) ||
		(pwrite && run && (sel_imem || sel_dmem)) ||
		(pwrite && (sel_status || sel_cycles));

	// First access cycle. pready follows one cycle later.
	assign access  = psel && penable && !pready;
	assign ctrl_wr = access && pwrite && sel_ctrl;

	assign imem_we   = access && pwrite && sel_imem && !addr_err;
	assign dmem_we   = access && pwrite && sel_dmem && !addr_err;
	assign mem_addr  = paddr[9:2];
	assign mem_wdata = pwdata;

	always_comb begin
		rd_mux = '0;
		if (sel_ctrl)
			rd_mux = {31'd0, run};
		else if (sel_status)
			rd_mux = {31'd0, halted};
		else if (sel_cycles)
			rd_mux = cycles;
		else if (sel_dmem)
			rd_mux = dmem_rdata;
	end

	assign prdata  = pready ? rd_mux : '0;
	assign pslverr = pready && addr_err;

	always_ff @(posedge input_clk) begin
		if (rst) begin
			pready <= 1'b0;
			run    <= 1'b0;
			halted <= 1'b0;
			cycles <= '0;
		end else begin
			pready <= access;
			if (ctrl_wr)
				run <= pwdata[0];
			// Starting clears the halt and the count.
			if (ctrl_wr && pwdata[0]) begin
				halted <= 1'b0;
				cycles <= '0;
			end else begin
				if (halt_wb && run && !halted)
					halted <= 1'b1;
				if (run && !halted)
					cycles <= cycles + 32'd1;
			end
		end
	end

endmodule

// ==== cpu5stage_top.sv ====
`timescale 1ns/1ns

module cpu5stage_top import cpu_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic        input_clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [11:0] paddr,
	input  xlen_t       pwdata,
	output xlen_t       prdata,
	output logic        pready,
	output logic        pslverr,
	output xlen_t       pc,
	output logic        halted
);

	logic       run;
	logic       imem_we;
	logic       dmem_we;
	logic       halt_wb;
	logic       halt_seen;
	logic       hazard;
	logic       ex_redirect;
	logic       running;
	logic       running_q;
	logic       restart;
	logic       stop;
	logic       drain;
	logic       redirect;
	logic [7:0] mem_addr;
	xlen_t      mem_wdata;
	xlen_t      dmem_rdata;
	xlen_t      ex_target;
	xlen_t      wb_data;
	fwd_sel_t   sel_a;
	fwd_sel_t   sel_b;
	fwd_sel_t   sel_store;
	if_id_t     if_d;
	if_id_t     if_id_q;
	id_ex_t     id_d;
	id_ex_t     id_ex_q;
	ex_mem_t    ex_d;
	ex_mem_t    ex_mem_q;
	ex_mem_t    mem_in;
	mem_wb_t    mem_d;
	mem_wb_t    mem_wb_q;

	assign running = run && !halted;
	assign stop    = !running;

	// First running cycle refetches from PC 0.
	always_ff @(posedge input_clk) begin
		if (rst)
			running_q <= 1'b0;
		else
			running_q <= running;
	end
	assign restart = running && !running_q;

	// The ecall left in WB by the last run is not a new halt.
	assign halt_seen = halt_wb && !restart;

	// Squash everything younger than an ecall.
	assign drain    = id_ex_q.ctrl.is_halt || ex_mem_q.ctrl.is_halt || mem_wb_q.ctrl.is_halt;
	assign redirect = restart || (ex_redirect && running);
	assign wb_data  = wb_value(mem_wb_q);

	always_comb begin
		mem_in               = ex_mem_q;
		mem_in.ctrl.memwrite = ex_mem_q.ctrl.memwrite && running && !restart;
	end

	cpu_ctrl_apb #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) ctrl0 (
		.input_clk(input_clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.halt_wb(halt_seen), .dmem_rdata(dmem_rdata), .run(run), .halted(halted),
		.imem_we(imem_we), .dmem_we(dmem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata));

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) if0 (
		.input_clk(input_clk), .rst(rst), .hold(hazard || stop), .redirect(redirect),
		.target(restart ? '0 : ex_target), .imem_we(imem_we), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .out_if(if_d), .pc(pc));

	pipe_reg #(.payload_t(if_id_t)) if_id_reg (
		.input_clk(input_clk), .rst(rst), .stall(hazard || stop),
		.flush((redirect || drain) && running), .d(if_d), .q(if_id_q));

	decode_stage id0 (
		.input_clk(input_clk), .rst(rst), .in_if(if_id_q), .wb(mem_wb_q),
		.ex_rd(id_ex_q.rd), .ex_memread(id_ex_q.ctrl.memread), .out_id(id_d),
		.hazard(hazard), .halt_wb(halt_wb));

	pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
		.input_clk(input_clk), .rst(rst), .stall(stop),
		.flush((hazard || redirect || drain) && running), .d(id_d), .q(id_ex_q));

	forward_unit fwd0 (
		.ex(id_ex_q), .mem(ex_mem_q), .wb(mem_wb_q),
		.sel_a(sel_a), .sel_b(sel_b), .sel_store(sel_store));

	execute_stage ex0 (
		.in_ex(id_ex_q), .mem_fwd(ex_mem_q.alu_out), .wb_fwd(wb_data),
		.sel_a(sel_a), .sel_b(sel_b), .sel_store(sel_store),
		.out_ex(ex_d), .redirect(ex_redirect), .target(ex_target));

	pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
		.input_clk(input_clk), .rst(rst), .stall(stop), .flush(restart),
		.d(ex_d), .q(ex_mem_q));

	memory_stage #(.DMEM_WORDS(DMEM_WORDS)) mem0 (
		.input_clk(input_clk), .rst(rst), .in_mem(mem_in), .out_wb(mem_d),
		.dmem_we(dmem_we), .dmem_addr(mem_addr), .mem_wdata(mem_wdata),
		.dmem_rdata(dmem_rdata));

	pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
		.input_clk(input_clk), .rst(rst), .stall(stop), .flush(restart),
		.d(mem_d), .q(mem_wb_q));

endmodule

// ==== cpu5stage_asserts.sv ====
`timescale 1ns/1ns

module cpu5stage_asserts import cpu_pkg::*; (
	input logic        input_clk,
	input logic        rst,
	input logic        psel,
	input logic        penable,
	input logic        pwrite,
	input logic [11:0] paddr,
	input logic        pready,
	input logic        pslverr,
	input logic        halted,
	input xlen_t       pc,
	input xlen_t       cycles
);

	int   failures = 0;
	logic read_mapped;

	// Reads fail only outside the address map.
	assign read_mapped = !pwrite && (paddr == CTRL_ADDR || paddr == STATUS_ADDR ||
		paddr == CYCLES_ADDR || paddr[11:10] == IMEM_BASE[11:10] ||
		paddr[11:10] == DMEM_BASE[11:10]);

	pready_in_access: assert property (@(posedge input_clk) disable iff (rst)
		pready |-> psel && penable)
	else begin
		failures++;
		$error("pready high outside an APB access");
	end

	pslverr_with_pready: assert property (@(posedge input_clk) disable iff (rst)
		pslverr |-> pready && !read_mapped)
	else begin
		failures++;
		$error("pslverr high without pready or on a mapped read");
	end

	// Core frozen once halted.
	halted_frozen: assert property (@(posedge input_clk) disable iff (rst)
		$past(halted) && halted |-> $stable(pc) && $stable(cycles))
	else begin
		failures++;
		$error("pc or cycle count moved while halted");
	end

	halted_after_reset: assert property (@(posedge input_clk)
		$fell(rst) |-> !halted)
	else begin
		failures++;
		$error("halted high right after reset");
	end

endmodule

bind cpu5stage_top cpu5stage_asserts asserts0 (
	.input_clk(input_clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
	.paddr(paddr), .pready(pready), .pslverr(pslverr), .halted(halted), .pc(pc),
	.cycles(ctrl0.cycles));

// ==== tb_cpu5stage.sv ====
`timescale 1ns/1ns

module tb_cpu5stage import cpu_pkg::*; ();

	localparam xlen_t ECALL = 32'h0000_0073;

	logic        input_clk;
	logic        rst;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [11:0] paddr;
	xlen_t       pwdata;
	xlen_t       prdata;
	logic        pready;
	logic        pslverr;
	xlen_t       pc;
	logic        halted;

	int    errors = 0;
	xlen_t prog [$];
	xlen_t mem_init [64];
	xlen_t mem_model [64];

	cpu5stage_top #(.IMEM_WORDS(256), .DMEM_WORDS(256)) dut0 (.*);

	initial begin
		input_clk = 1'b0;
		forever #4 input_clk = ~input_clk;
	end

	function automatic xlen_t enc_r(logic [2:0] f3, logic alt, int rd, int rs1, int rs2);
		return {1'b0, alt, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_R};
	endfunction

	function automatic xlen_t enc_i(logic [6:0] op, logic [2:0] f3, int rd, int rs1, int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), op};
	endfunction

	function automatic xlen_t enc_s(int rs1, int rs2, int imm);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], OP_STORE};
	endfunction

	function automatic xlen_t enc_b(logic [2:0] f3, int rs1, int rs2, int off);
		logic [12:0] i;
		i = 13'(off);
		return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], OP_BRANCH};
	endfunction

	function automatic xlen_t enc_j(int rd, int off);
		logic [20:0] i;
		i = 21'(off);
		return {i[20], i[10:1], i[11], i[19:12], 5'(rd), OP_JAL};
	endfunction

	task automatic check_word(input string name, input xlen_t expected, input xlen_t actual);
		assert (actual === expected) else begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// One APB transfer through setup and access until pready.
	task automatic apb_access(input logic wr, input logic [11:0] addr, input xlen_t wdata,
		output xlen_t rdata, output logic err);
		int waited;
		@(posedge input_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge input_clk);
		penable <= 1'b1;
		waited = 0;
		do begin
			@(negedge input_clk);
			waited++;
		end while (!pready && waited < 16);
		if (!pready) begin
			errors++;
			$display("APB transfer at address %h got no pready in time", addr);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge input_clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [11:0] addr, input xlen_t data, output logic err);
		xlen_t unused;
		apb_access(1'b1, addr, data, unused, err);
	endtask

	task automatic apb_read(input logic [11:0] addr, output xlen_t data, output logic err);
		apb_access(1'b0, addr, '0, data, err);
	endtask

	task automatic fill_dmem();
		foreach (mem_init[i])
			mem_init[i] = {24'h5A5A5A, 8'(i * 4)};
	endtask

	// ISA level model of the program in prog.
	task automatic run_model();
		xlen_t r [32];
		xlen_t pc_m;
		xlen_t next;
		xlen_t inst;
		xlen_t a;
		xlen_t b;
		xlen_t res;
		xlen_t imm_i;
		xlen_t imm_s;
		xlen_t imm_b;
		xlen_t imm_j;
		logic  wr;
		logic  done;
		int    steps;
		mem_model = mem_init;
		r     = '{default: '0};
		pc_m  = '0;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 200) begin
			inst  = prog[pc_m >> 2];
			a     = r[inst[19:15]];
			b     = r[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			next  = pc_m + 32'd4;
			wr    = 1'b0;
			res   = '0;
			steps++;
			case (inst[6:0])
				OP_R: begin
					wr = 1'b1;
					case (inst[14:12])
						3'b000: res = inst[30] ? a - b : a + b;
						3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						default: res = a & b;
					endcase
				end
				OP_IMM: begin
					wr  = 1'b1;
					res = a + imm_i;
				end
				OP_LOAD: begin
					wr  = 1'b1;
					res = mem_model[(a + imm_i) >> 2];
				end
				OP_STORE: mem_model[(a + imm_s) >> 2] = b;
				OP_BRANCH: begin
					if ((inst[14:12] == 3'b000 && a == b) || (inst[14:12] == 3'b001 && a != b))
						next = pc_m + imm_b;
				end
				OP_JAL: begin
					wr   = 1'b1;
					res  = pc_m + 32'd4;
					next = pc_m + imm_j;
				end
				OP_SYSTEM: done = 1'b1;
				default: ;
			endcase
			if (wr && inst[11:7] != 5'd0)
				r[inst[11:7]] = res;
			pc_m = next;
		end
	endtask

	task automatic run_program(input string name, input logic load_imem);
		xlen_t rd_val;
		logic  err;
		int    waited;
		apb_write(CTRL_ADDR, 32'd0, err);
		if (load_imem) begin
			foreach (prog[i])
				apb_write(IMEM_BASE + 12'(i * 4), prog[i], err);
		end
		foreach (mem_init[i])
			apb_write(DMEM_BASE + 12'(i * 4), mem_init[i], err);
		apb_write(CTRL_ADDR, 32'd1, err);
		waited = 0;
		do begin
			@(negedge input_clk);
			waited++;
		end while (!halted && waited < 1000);
		if (!halted) begin
			errors++;
			$display("%s: core did not halt within 1000 cycles", name);
		end
		run_model();
		foreach (mem_model[i]) begin
			apb_read(DMEM_BASE + 12'(i * 4), rd_val, err);
			check_word($sformatf("%s word %0d", name, i), mem_model[i], rd_val);
		end
	endtask

	initial begin
		xlen_t rd_val;
		xlen_t cycles_a;
		xlen_t cycles_b;
		logic  err;
		int    imm;
		void'($urandom(56567));
		rst     = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (4) @(posedge input_clk);
		rst <= 1'b0;
		@(negedge input_clk);
		check_word("reset pc", 32'd0, pc);
		check_word("reset halted", 32'd0, halted);
		check_word("idle pready", 32'd0, pready);
		check_word("idle pslverr", 32'd0, pslverr);
		apb_read(STATUS_ADDR, rd_val, err);
		check_word("reset status", 32'd0, rd_val);
		apb_read(CTRL_ADDR, rd_val, err);
		check_word("reset ctrl", 32'd0, rd_val);

		// Each op uses the result just before it.
		fill_dmem();
		mem_init[0] = $urandom();
		mem_init[1] = $urandom();
		imm = int'($urandom() % 4096) - 2048;
		prog = {
			enc_i(OP_LOAD, 3'b010, 2, 0, 4),
			enc_i(OP_LOAD, 3'b010, 1, 0, 0),
			enc_i(OP_IMM, 3'b000, 3, 1, imm),
			enc_r(3'b000, 1'b0, 4, 3, 2),
			enc_r(3'b000, 1'b1, 5, 4, 1),
			enc_r(3'b100, 1'b0, 6, 5, 4),
			enc_r(3'b010, 1'b0, 7, 6, 5),
			enc_s(0, 3, 64),
			enc_s(0, 4, 68),
			enc_s(0, 5, 72),
			enc_s(0, 6, 76),
			enc_s(0, 7, 80),
			ECALL
		};
		run_program("alu chain", 1'b1);

		// Load-use followed by a store of the previous result.
		fill_dmem();
		mem_init[2] = $urandom();
		prog = {
			enc_i(OP_LOAD, 3'b010, 8, 0, 8),
			enc_r(3'b000, 1'b0, 9, 8, 8),
			enc_i(OP_IMM, 3'b000, 10, 9, -3),
			enc_s(0, 10, 96),
			enc_s(0, 9, 100),
			ECALL
		};
		run_program("load use", 1'b1);

		// Wrong path stores hit marker words.
		fill_dmem();
		prog = {
			enc_i(OP_IMM, 3'b000, 11, 0, 7),
			enc_i(OP_IMM, 3'b000, 12, 0, 7),
			enc_b(3'b000, 11, 12, 12),
			enc_s(0, 11, 128),
			enc_s(0, 11, 132),
			enc_b(3'b001, 11, 12, 8),
			enc_s(0, 12, 136),
			enc_j(13, 12),
			enc_s(0, 11, 140),
			enc_s(0, 11, 144),
			enc_s(0, 13, 148),
			ECALL
		};
		run_program("control flow", 1'b1);

		apb_read(STATUS_ADDR, rd_val, err);
		check_word("status after halt", 32'd1, rd_val);
		apb_read(CYCLES_ADDR, cycles_a, err);
		apb_read(CYCLES_ADDR, rd_val, err);
		check_word("cycles while halted", cycles_a, rd_val);

		apb_write(IMEM_BASE, enc_s(0, 0, 128), err);
		check_word("imem write while running", 32'd1, err);
		apb_write(STATUS_ADDR, 32'd0, err);
		check_word("status write", 32'd1, err);
		apb_read(STATUS_ADDR, rd_val, err);
		check_word("status kept", 32'd1, rd_val);
		apb_read(12'h00C, rd_val, err);
		check_word("unmapped read", 32'd1, err);
		apb_write(DMEM_BASE + 12'd128, 32'd0, err);
		check_word("dmem write while running", 32'd1, err);
		apb_read(DMEM_BASE + 12'd128, rd_val, err);
		check_word("dmem after refused write", mem_model[32], rd_val);

		// Rerun from PC 0 with the old image.
		run_program("restart", 1'b0);
		apb_read(CYCLES_ADDR, cycles_b, err);
		check_word("cycles on restart", cycles_a, cycles_b);

		$display("Errors: %0d check failures, %0d assertion failures",
			errors, dut0.asserts0.failures);
		if (errors == 0 && dut0.asserts0.failures == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== list.f ====
cpu_pkg.sv
pipe_reg.sv
fetch_stage.sv
decode_stage.sv
forward_unit.sv
execute_stage.sv
memory_stage.sv
cpu_ctrl_apb.sv
cpu5stage_top.sv
cpu5stage_asserts.sv
tb_cpu5stage.sv
